/* source/dual_issue_macros.svh */
`ifndef DUAL_ISSUE_MACROS_SVH
`define DUAL_ISSUE_MACROS_SVH

// data word width
`define XLEN 32

// register index width, 32 registers
`define REG_ADDR_W 5

// issue width, pairing logic assumes two
`define NUM_LANES 2

`endif

/* source/dual_issue_pkg.sv */
`include "dual_issue_macros.svh"

package dual_issue_pkg;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_addr_t;

    // register format
    typedef struct packed {
        logic [5:0] opcode;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        logic [4:0] shamt;
        logic [5:0] funct;
    } r_fields_t;

    // immediate format
    typedef struct packed {
        logic [5:0]  opcode;
        reg_addr_t   rs;
        reg_addr_t   rt;
        logic [15:0] imm;
    } i_fields_t;

    // opcode picks which view is valid
    typedef union packed {
        r_fields_t r;
        i_fields_t i;
    } instr_u;

    typedef enum logic [3:0] {
        OP_NOP,
        OP_ADDU,
        OP_SUBU,
        OP_AND,
        OP_OR,
        OP_XOR,
        OP_SLT,
        OP_SLL,
        OP_LUI,
        OP_MULTU,
        OP_MTHI,
        OP_MTLO
    } alu_op_e;

endpackage

/* source/regfile.sv */
`include "dual_issue_macros.svh"

module regfile import dual_issue_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  reg_addr_t             ra [2*`NUM_LANES],
    output word_t                 rd [2*`NUM_LANES],
    input  logic [`NUM_LANES-1:0] we,
    input  reg_addr_t             wa [`NUM_LANES],
    input  word_t                 wd [`NUM_LANES]
);

    word_t regs [1<<`REG_ADDR_W];

    // r0 hardwired to zero
    always_comb begin
        for (int k = 0; k < 2*`NUM_LANES; k++) begin
            rd[k] = (ra[k] == '0) ? '0 : regs[ra[k]];
        end
    end

    // later port overrides earlier on the same address
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int r = 0; r < (1<<`REG_ADDR_W); r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < `NUM_LANES; w++) begin
                if (we[w] && wa[w] != '0) begin
                    regs[wa[w]] <= wd[w];
                end
            end
        end
    end

endmodule

/* source/issue_unit.sv */
`include "dual_issue_macros.svh"

module issue_unit import dual_issue_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  instr_u                instr0,
    input  instr_u                instr1,
    input  logic                  in_valid,
    output logic                  in_ready,
    output reg_addr_t             ra [2*`NUM_LANES],
    input  word_t                 rd [2*`NUM_LANES],
    input  logic [`NUM_LANES-1:0] fwd_valid,
    input  reg_addr_t             fwd_wa [`NUM_LANES],
    input  word_t                 fwd_wd [`NUM_LANES],
    input  logic [`NUM_LANES-1:0] res_valid,
    input  reg_addr_t             res_wa [`NUM_LANES],
    input  word_t                 res_wd [`NUM_LANES],
    output alu_op_e               op [`NUM_LANES],
    output word_t                 a [`NUM_LANES],
    output word_t                 b [`NUM_LANES],
    output reg_addr_t             wa [`NUM_LANES],
    output logic [`NUM_LANES-1:0] issue_valid
);

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] FN_SLL      = 6'h00;
    localparam logic [5:0] FN_MTHI     = 6'h11;
    localparam logic [5:0] FN_MTLO     = 6'h13;
    localparam logic [5:0] FN_MULTU    = 6'h19;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUBU     = 6'h23;
    localparam logic [5:0] FN_AND      = 6'h24;
    localparam logic [5:0] FN_OR       = 6'h25;
    localparam logic [5:0] FN_XOR      = 6'h26;
    localparam logic [5:0] FN_SLT      = 6'h2a;

    logic                  held;
    instr_u                held_instr;
    instr_u                slot [`NUM_LANES];
    alu_op_e               dec_op [`NUM_LANES];
    reg_addr_t             dec_wa [`NUM_LANES];
    reg_addr_t             src_a [`NUM_LANES];
    reg_addr_t             src_b [`NUM_LANES];
    logic                  b_imm [`NUM_LANES];
    word_t                 imm [`NUM_LANES];
    word_t                 opnd [2*`NUM_LANES];
    logic                  split;
    logic [`NUM_LANES-1:0] go;

    // a held younger instruction goes out alone on lane 0
    assign slot[0] = held ? held_instr : instr0;
    assign slot[1] = instr1;
    assign in_ready = ~held;

    // unused sources stay at r0 so they never match a destination
    always_comb begin
        for (int i = 0; i < `NUM_LANES; i++) begin
            dec_op[i] = OP_NOP;
            dec_wa[i] = '0;
            src_a[i] = '0;
            src_b[i] = '0;
            b_imm[i] = 1'b0;
            imm[i] = '0;
            if (slot[i].r.opcode == OPC_SPECIAL) begin
                src_a[i] = slot[i].r.rs;
                src_b[i] = slot[i].r.rt;
                dec_wa[i] = slot[i].r.rd;
                case (slot[i].r.funct)
                    FN_ADDU: dec_op[i] = OP_ADDU;
                    FN_SUBU: dec_op[i] = OP_SUBU;
                    FN_AND:  dec_op[i] = OP_AND;
                    FN_OR:   dec_op[i] = OP_OR;
                    FN_XOR:  dec_op[i] = OP_XOR;
                    FN_SLT:  dec_op[i] = OP_SLT;
                    FN_SLL: begin
                        dec_op[i] = OP_SLL;
                        src_a[i] = slot[i].r.rt;
                        src_b[i] = '0;
                        b_imm[i] = 1'b1;
                        imm[i] = word_t'(slot[i].r.shamt);
                    end
                    FN_MULTU: begin
                        dec_op[i] = OP_MULTU;
                        dec_wa[i] = '0;
                    end
                    FN_MTHI, FN_MTLO: begin
                        dec_op[i] = (slot[i].r.funct == FN_MTHI) ? OP_MTHI : OP_MTLO;
                        src_b[i] = '0;
                        dec_wa[i] = '0;
                    end
                    default: begin
                        src_a[i] = '0;
                        src_b[i] = '0;
                        dec_wa[i] = '0;
                    end
                endcase
            end else begin
                src_a[i] = slot[i].i.rs;
                dec_wa[i] = slot[i].i.rt;
                b_imm[i] = 1'b1;
                imm[i] = {{(`XLEN-16){slot[i].i.imm[15]}}, slot[i].i.imm};
                case (slot[i].i.opcode)
                    OPC_ADDIU: dec_op[i] = OP_ADDU;
                    OPC_SLTI:  dec_op[i] = OP_SLT;
                    OPC_ANDI, OPC_ORI, OPC_XORI: begin
                        imm[i] = word_t'(slot[i].i.imm);
                        dec_op[i] = (slot[i].i.opcode == OPC_ANDI) ? OP_AND :
                                    (slot[i].i.opcode == OPC_ORI)  ? OP_OR : OP_XOR;
                    end
                    OPC_LUI: begin
                        dec_op[i] = OP_LUI;
                        src_a[i] = '0;
                        imm[i] = word_t'(slot[i].i.imm);
                    end
                    default: begin
                        src_a[i] = '0;
                        dec_wa[i] = '0;
                    end
                endcase
            end
            ra[2*i] = src_a[i];
            ra[2*i+1] = src_b[i];
        end
    end

    // newest producer wins, lane 1 over lane 0 within a stage
    always_comb begin
        for (int k = 0; k < 2*`NUM_LANES; k++) begin
            opnd[k] = rd[k];
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (res_valid[l] && res_wa[l] == ra[k] && ra[k] != '0) begin
                    opnd[k] = res_wd[l];
                end
            end
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (fwd_valid[l] && fwd_wa[l] == ra[k] && ra[k] != '0) begin
                    opnd[k] = fwd_wd[l];
                end
            end
        end
    end

    // younger reads older's result
    assign split = ~held & in_valid & (dec_wa[0] != '0) &
                   (src_a[1] == dec_wa[0] || src_b[1] == dec_wa[0]);
    assign go[0] = held | in_valid;
    assign go[1] = ~held & in_valid & ~split;

    always_ff @(posedge clk) begin
        for (int l = 0; l < `NUM_LANES; l++) begin
            op[l] <= dec_op[l];
            a[l] <= opnd[2*l];
            b[l] <= b_imm[l] ? imm[l] : opnd[2*l+1];
            wa[l] <= dec_wa[l];
        end
        if (split) begin
            held_instr <= instr1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            issue_valid <= '0;
            held <= 1'b0;
        end else begin
            issue_valid <= go;
            held <= split;
        end
    end

endmodule

/* source/alu_lane.sv */
`include "dual_issue_macros.svh"

module alu_lane import dual_issue_pkg::*; (
    input  logic       clk,
    input  logic       reset,
    input  alu_op_e    op,
    input  word_t      a,
    input  word_t      b,
    input  reg_addr_t  wa,
    input  logic       issue_valid,
    output logic       fwd_valid,
    output reg_addr_t  fwd_wa,
    output word_t      fwd_wd,
    output logic       res_valid,
    output reg_addr_t  res_wa,
    output word_t      res_wd,
    output word_t      res_hi,
    output word_t      res_lo,
    output logic [1:0] res_hilo_we
);

    logic [2*`XLEN-1:0] product;
    word_t              result;
    word_t              hi_c;
    word_t              lo_c;
    logic [1:0]         hilo_we;

    assign product = {{`XLEN{1'b0}}, a} * {{`XLEN{1'b0}}, b};

    always_comb begin
        case (op)
            OP_ADDU: result = a + b;
            OP_SUBU: result = a - b;
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_SLT:  result = word_t'($signed(a) < $signed(b));
            OP_SLL:  result = a << b[4:0];
            OP_LUI:  result = {b[15:0], 16'h0000};
            default: result = '0;
        endcase
    end

    // hi in bit 1, lo in bit 0
    always_comb begin
        case (op)
            OP_MULTU: hilo_we = 2'b11;
            OP_MTHI:  hilo_we = 2'b10;
            OP_MTLO:  hilo_we = 2'b01;
            default:  hilo_we = 2'b00;
        endcase
        if (!issue_valid) begin
            hilo_we = 2'b00;
        end
    end

    assign hi_c = (op == OP_MTHI) ? a : product[2*`XLEN-1:`XLEN];
    assign lo_c = (op == OP_MTLO) ? a : product[`XLEN-1:0];

    assign fwd_valid = issue_valid && wa != '0;
    assign fwd_wa = wa;
    assign fwd_wd = result;

    always_ff @(posedge clk) begin
        res_wa <= wa;
        res_wd <= result;
        res_hi <= hi_c;
        res_lo <= lo_c;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
            res_hilo_we <= 2'b00;
        end else begin
            res_valid <= issue_valid;
            res_hilo_we <= hilo_we;
        end
    end

endmodule

/* source/commit_unit.sv */
`include "dual_issue_macros.svh"

module commit_unit import dual_issue_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [`NUM_LANES-1:0] res_valid,
    input  reg_addr_t             res_wa [`NUM_LANES],
    input  word_t                 res_wd [`NUM_LANES],
    input  word_t                 res_hi [`NUM_LANES],
    input  word_t                 res_lo [`NUM_LANES],
    input  logic [1:0]            res_hilo_we [`NUM_LANES],
    output logic [`NUM_LANES-1:0] we,
    output reg_addr_t             wa [`NUM_LANES],
    output word_t                 wd [`NUM_LANES],
    output logic [`NUM_LANES-1:0] commit_valid,
    output reg_addr_t             commit_wa [`NUM_LANES],
    output word_t                 commit_wd [`NUM_LANES],
    output word_t                 hi,
    output word_t                 lo
);

    // writes to r0 are dropped here
    always_comb begin
        for (int l = 0; l < `NUM_LANES; l++) begin
            we[l] = res_valid[l] && res_wa[l] != '0;
            wa[l] = res_wa[l];
            wd[l] = res_wd[l];
            commit_valid[l] = we[l];
            commit_wa[l] = res_wa[l];
            commit_wd[l] = res_wd[l];
        end
    end

    // loop order lets lane 1 override lane 0
    always_ff @(posedge clk) begin
        if (reset) begin
            hi <= '0;
            lo <= '0;
        end else begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (res_valid[l] && res_hilo_we[l][1]) begin
                    hi <= res_hi[l];
                end
                if (res_valid[l] && res_hilo_we[l][0]) begin
                    lo <= res_lo[l];
                end
            end
        end
    end

endmodule

/* source/dual_issue_top.sv */
`include "dual_issue_macros.svh"

module dual_issue_top import dual_issue_pkg::*; (
    input  logic                  clk,
    input  logic                  reset,
    input  instr_u                instr0,
    input  instr_u                instr1,
    input  logic                  in_valid,
    output logic                  in_ready,
    output logic [`NUM_LANES-1:0] commit_valid,
    output reg_addr_t             commit_wa [`NUM_LANES],
    output word_t                 commit_wd [`NUM_LANES],
    output word_t                 hi,
    output word_t                 lo
);

    reg_addr_t             ra [2*`NUM_LANES];
    word_t                 rd [2*`NUM_LANES];
    alu_op_e               op [`NUM_LANES];
    word_t                 a [`NUM_LANES];
    word_t                 b [`NUM_LANES];
    reg_addr_t             wa [`NUM_LANES];
    logic [`NUM_LANES-1:0] issue_valid;
    logic [`NUM_LANES-1:0] fwd_valid;
    reg_addr_t             fwd_wa [`NUM_LANES];
    word_t                 fwd_wd [`NUM_LANES];
    logic [`NUM_LANES-1:0] res_valid;
    reg_addr_t             res_wa [`NUM_LANES];
    word_t                 res_wd [`NUM_LANES];
    word_t                 res_hi [`NUM_LANES];
    word_t                 res_lo [`NUM_LANES];
    logic [1:0]            res_hilo_we [`NUM_LANES];
    logic [`NUM_LANES-1:0] rf_we;
    reg_addr_t             rf_wa [`NUM_LANES];
    word_t                 rf_wd [`NUM_LANES];

    issue_unit issue0 (
        .clk, .reset, .instr0, .instr1, .in_valid, .in_ready,
        .ra, .rd, .fwd_valid, .fwd_wa, .fwd_wd, .res_valid, .res_wa, .res_wd,
        .op, .a, .b, .wa, .issue_valid
    );

    regfile regs0 (
        .clk, .reset, .ra, .rd, .we(rf_we), .wa(rf_wa), .wd(rf_wd)
    );

    for (genvar g = 0; g < `NUM_LANES; g++) begin : g_lane
        alu_lane lane (
            .clk, .reset,
            .op(op[g]), .a(a[g]), .b(b[g]), .wa(wa[g]), .issue_valid(issue_valid[g]),
            .fwd_valid(fwd_valid[g]), .fwd_wa(fwd_wa[g]), .fwd_wd(fwd_wd[g]),
            .res_valid(res_valid[g]), .res_wa(res_wa[g]), .res_wd(res_wd[g]),
            .res_hi(res_hi[g]), .res_lo(res_lo[g]), .res_hilo_we(res_hilo_we[g])
        );
    end

    commit_unit commit0 (
        .clk, .reset, .res_valid, .res_wa, .res_wd, .res_hi, .res_lo, .res_hilo_we,
        .we(rf_we), .wa(rf_wa), .wd(rf_wd),
        .commit_valid, .commit_wa, .commit_wd, .hi, .lo
    );

endmodule

/* bench/clock_gen.sv */
module clock_gen (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // held over the first 16 rising edges
    initial begin
        reset = 1'b1;
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

/* bench/dual_issue_chk.sv */
`include "dual_issue_macros.svh"

module dual_issue_chk import dual_issue_pkg::*; (
    input logic                  clk,
    input logic                  reset,
    input logic                  in_ready,
    input logic [`NUM_LANES-1:0] commit_valid,
    input word_t                 hi,
    input word_t                 lo
);

    // a split stalls the input for one cycle only
    assert property (@(posedge clk) disable iff (reset) !in_ready |=> in_ready)
        else $error("in_ready low for two cycles in a row");

    // older half of a split commits on lane 0 in the cycle after the stall
    assert property (@(posedge clk) disable iff (reset) !in_ready |=> commit_valid[0])
        else $error("older instruction of a split pair did not commit on lane 0");

    assert property (@(posedge clk) reset |=> (commit_valid == '0) && in_ready)
        else $error("commit valid or input stalled right after reset");

    assert property (@(posedge clk) $fell(reset) |-> (hi == '0) && (lo == '0))
        else $error("hi or lo nonzero when reset is released");

endmodule

bind dual_issue_top dual_issue_chk chk0 (
    .clk, .reset, .in_ready, .commit_valid, .hi, .lo
);

/* bench/dual_issue_tb.sv */
`include "dual_issue_macros.svh"

module dual_issue_tb import dual_issue_pkg::*; ();

    localparam logic [5:0] OPC_SPECIAL = 6'h00;
    localparam logic [5:0] OPC_ADDIU   = 6'h09;
    localparam logic [5:0] OPC_SLTI    = 6'h0a;
    localparam logic [5:0] OPC_ANDI    = 6'h0c;
    localparam logic [5:0] OPC_ORI     = 6'h0d;
    localparam logic [5:0] OPC_XORI    = 6'h0e;
    localparam logic [5:0] OPC_LUI     = 6'h0f;
    localparam logic [5:0] FN_SLL      = 6'h00;
    localparam logic [5:0] FN_MTHI     = 6'h11;
    localparam logic [5:0] FN_MTLO     = 6'h13;
    localparam logic [5:0] FN_MULTU    = 6'h19;
    localparam logic [5:0] FN_ADDU     = 6'h21;
    localparam logic [5:0] FN_SUBU     = 6'h23;
    localparam logic [5:0] FN_AND      = 6'h24;
    localparam logic [5:0] FN_OR       = 6'h25;
    localparam logic [5:0] FN_XOR      = 6'h26;
    localparam logic [5:0] FN_SLT      = 6'h2a;

    // last entry of each table is an unsupported encoding
    localparam logic [5:0] R_FUNCT [11] = '{FN_ADDU, FN_SUBU, FN_AND, FN_OR, FN_XOR, FN_SLT,
                                            FN_SLL, FN_MULTU, FN_MTHI, FN_MTLO, 6'h27};
    localparam logic [5:0] I_OPC [7] = '{OPC_ADDIU, OPC_SLTI, OPC_ANDI, OPC_ORI, OPC_XORI,
                                         OPC_LUI, 6'h23};

    localparam int NUM_PAIRS  = 400;
    localparam int WAIT_LIMIT = 20;

    logic                  clk;
    logic                  reset;
    instr_u                instr0;
    instr_u                instr1;
    logic                  in_valid;
    logic                  in_ready;
    logic [`NUM_LANES-1:0] commit_valid;
    reg_addr_t             commit_wa [`NUM_LANES];
    word_t                 commit_wd [`NUM_LANES];
    word_t                 hi;
    word_t                 lo;

    integer    seed;
    string     test_name;
    word_t     model_rf [1<<`REG_ADDR_W];
    word_t     model_hi;
    word_t     model_lo;
    reg_addr_t exp_wa [$];
    word_t     exp_wd [$];

    clock_gen clkgen0 (.clk, .reset);

    dual_issue_top dut0 (
        .clk, .reset, .instr0, .instr1, .in_valid, .in_ready,
        .commit_valid, .commit_wa, .commit_wd, .hi, .lo
    );

    task automatic stop_sim();
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic check_commit(input reg_addr_t exp_a, input word_t exp_d,
                                input reg_addr_t act_a, input word_t act_d);
        if (exp_a !== act_a || exp_d !== act_d) begin
            $display("ERROR %s: commit expected r%0d=%h, actual r%0d=%h",
                     test_name, exp_a, exp_d, act_a, act_d);
            stop_sim();
        end
    endtask

    task automatic check_hilo(input word_t exp_hi, input word_t exp_lo,
                              input word_t act_hi, input word_t act_lo);
        if (exp_hi !== act_hi || exp_lo !== act_lo) begin
            $display("ERROR %s: hi/lo expected %h/%h, actual %h/%h",
                     test_name, exp_hi, exp_lo, act_hi, act_lo);
            stop_sim();
        end
    endtask

    function automatic instr_u r_instr(logic [5:0] funct, reg_addr_t rs, reg_addr_t rt,
                                       reg_addr_t rd, logic [4:0] shamt);
        instr_u w;
        w.r = '{opcode: OPC_SPECIAL, rs: rs, rt: rt, rd: rd, shamt: shamt, funct: funct};
        return w;
    endfunction

    function automatic instr_u i_instr(logic [5:0] opc, reg_addr_t rs, reg_addr_t rt,
                                       logic [15:0] imm);
        instr_u w;
        w.i = '{opcode: opc, rs: rs, rt: rt, imm: imm};
        return w;
    endfunction

    // r0..r5 only, so dependences are common
    function automatic reg_addr_t pick_reg();
        logic [31:0] rnd;
        rnd = $random(seed);
        return reg_addr_t'(rnd[15:0] % 16'd6);
    endfunction

    function automatic instr_u rand_instr();
        logic [31:0] rnd;
        logic [15:0] kind;
        instr_u      w;
        rnd = $random(seed);
        kind = rnd[31:16] % 16'd18;
        if (kind < 16'd11) begin
            w = r_instr(R_FUNCT[4'(kind)], pick_reg(), pick_reg(), pick_reg(), rnd[4:0]);
        end else begin
            w = i_instr(I_OPC[3'(kind - 16'd11)], pick_reg(), pick_reg(), rnd[15:0]);
        end
        return w;
    endfunction

    // in-order reference, also reports the sources and destination used for pairing
    task automatic model_exec(input instr_u w, output reg_addr_t dst,
                              output reg_addr_t sa, output reg_addr_t sb);
        word_t       rs_v;
        word_t       rt_v;
        word_t       simm;
        word_t       zimm;
        word_t       res;
        logic [63:0] prod;
        logic        wr;
        rs_v = model_rf[w.r.rs];
        rt_v = model_rf[w.r.rt];
        simm = {{16{w.i.imm[15]}}, w.i.imm};
        zimm = {16'h0000, w.i.imm};
        prod = {32'h0, rs_v} * {32'h0, rt_v};
        res = '0;
        dst = '0;
        sb = '0;
        sa = w.r.rs;
        wr = 1'b1;
        if (w.r.opcode == OPC_SPECIAL) begin
            sb = w.r.rt;
            case (w.r.funct)
                FN_ADDU: res = rs_v + rt_v;
                FN_SUBU: res = rs_v - rt_v;
                FN_AND:  res = rs_v & rt_v;
                FN_OR:   res = rs_v | rt_v;
                FN_XOR:  res = rs_v ^ rt_v;
                FN_SLT:  res = word_t'($signed(rs_v) < $signed(rt_v));
                FN_SLL: begin
                    res = rt_v << w.r.shamt;
                    sa = w.r.rt;
                    sb = '0;
                end
                FN_MULTU: begin
                    {model_hi, model_lo} = prod;
                    wr = 1'b0;
                end
                FN_MTHI, FN_MTLO: begin
                    if (w.r.funct == FN_MTHI) begin
                        model_hi = rs_v;
                    end else begin
                        model_lo = rs_v;
                    end
                    sb = '0;
                    wr = 1'b0;
                end
                default: begin
                    sa = '0;
                    sb = '0;
                    wr = 1'b0;
                end
            endcase
            if (wr) begin
                dst = w.r.rd;
            end
        end else begin
            case (w.i.opcode)
                OPC_ADDIU: res = rs_v + simm;
                OPC_SLTI:  res = word_t'($signed(rs_v) < $signed(simm));
                OPC_ANDI:  res = rs_v & zimm;
                OPC_ORI:   res = rs_v | zimm;
                OPC_XORI:  res = rs_v ^ zimm;
                OPC_LUI: begin
                    res = {w.i.imm, 16'h0000};
                    sa = '0;
                end
                default: begin
                    sa = '0;
                    wr = 1'b0;
                end
            endcase
            if (wr) begin
                dst = w.i.rt;
            end
        end
        // r0 stays zero and never commits
        if (dst != '0) begin
            model_rf[dst] = res;
            exp_wa.push_back(dst);
            exp_wd.push_back(res);
        end
    endtask

    task automatic send_pair(input instr_u i0, input instr_u i1);
        reg_addr_t d0;
        reg_addr_t s0a;
        reg_addr_t s0b;
        reg_addr_t d1;
        reg_addr_t s1a;
        reg_addr_t s1b;
        logic      split;
        int        t;
        t = 0;
        while (!in_ready) begin
            @(posedge clk);
            #1;
            t++;
            if (t > WAIT_LIMIT) begin
                $display("in_ready stayed low while waiting to send a pair");
                stop_sim();
            end
        end
        instr0 = i0;
        instr1 = i1;
        in_valid = 1'b1;
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        model_exec(i0, d0, s0a, s0b);
        model_exec(i1, d1, s1a, s1b);
        // younger reads the older destination
        split = (d0 != '0) && (s1a == d0 || s1b == d0);
        if (in_ready !== !split) begin
            $display("ERROR %s: in_ready after pair expected %b, actual %b",
                     test_name, !split, in_ready);
            stop_sim();
        end
        if (split) begin
            @(posedge clk);
            #1;
            if (!in_ready) begin
                $display("in_ready stayed low for a second cycle after a split");
                stop_sim();
            end
        end
    endtask

    task automatic drain_check();
        int t;
        in_valid = 1'b0;
        // hi and lo land two edges after the last issue
        repeat (2) @(posedge clk);
        #1;
        t = 0;
        while (exp_wa.size() != 0) begin
            @(posedge clk);
            #1;
            t++;
            if (t > WAIT_LIMIT) begin
                $display("expected commits never appeared on the commit ports");
                stop_sim();
            end
        end
        check_hilo(model_hi, model_lo, hi, lo);
    endtask

    // lane 0 is the older commit within a cycle
    always @(negedge clk) begin
        if (!reset) begin
            for (int l = 0; l < `NUM_LANES; l++) begin
                if (commit_valid[l]) begin
                    if (exp_wa.size() == 0) begin
                        $display("lane %0d committed r%0d with no commit pending", l,
                                 commit_wa[l]);
                        stop_sim();
                    end else begin
                        check_commit(exp_wa.pop_front(), exp_wd.pop_front(),
                                     commit_wa[l], commit_wd[l]);
                    end
                end
            end
        end
    end

    initial begin
        int t;
        seed = 29769;
        test_name = "reset";
        instr0 = '0;
        instr1 = '0;
        in_valid = 1'b0;
        for (int r = 0; r < (1<<`REG_ADDR_W); r++) begin
            model_rf[r] = '0;
        end
        model_hi = '0;
        model_lo = '0;
        t = 0;
        @(posedge clk);
        while (reset) begin
            @(posedge clk);
            t++;
            if (t > 40) begin
                $display("reset was never released");
                stop_sim();
            end
        end
        #1;
        if (!in_ready || commit_valid != '0) begin
            $display("after reset in_ready is low or a commit is already valid");
            stop_sim();
        end
        check_hilo('0, '0, hi, lo);

        test_name = "split";
        send_pair(i_instr(OPC_ADDIU, 5'd0, 5'd1, 16'h0005),
                  r_instr(FN_ADDU, 5'd1, 5'd1, 5'd2, 5'd0));
        drain_check();

        test_name = "hilo";
        send_pair(i_instr(OPC_ADDIU, 5'd0, 5'd3, 16'h1234),
                  i_instr(OPC_LUI, 5'd0, 5'd4, 16'h8765));
        send_pair(r_instr(FN_MTHI, 5'd3, 5'd0, 5'd0, 5'd0),
                  r_instr(FN_MTHI, 5'd4, 5'd0, 5'd0, 5'd0));
        drain_check();
        send_pair(r_instr(FN_MULTU, 5'd3, 5'd4, 5'd0, 5'd0),
                  r_instr(FN_MTLO, 5'd1, 5'd0, 5'd0, 5'd0));
        drain_check();

        test_name = "r0";
        send_pair(i_instr(OPC_ADDIU, 5'd0, 5'd0, 16'h0007),
                  r_instr(FN_ADDU, 5'd0, 5'd0, 5'd3, 5'd0));
        drain_check();

        test_name = "random";
        for (int n = 0; n < NUM_PAIRS; n++) begin
            if (($random(seed) & 7) == 0) begin
                in_valid = 1'b0;
                @(posedge clk);
                #1;
            end
            send_pair(rand_instr(), rand_instr());
            if (n % 8 == 7) begin
                drain_check();
            end
        end
        drain_check();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* dual_issue.f */
+incdir+source
source/dual_issue_pkg.sv
source/regfile.sv
source/issue_unit.sv
source/alu_lane.sv
source/commit_unit.sv
source/dual_issue_top.sv
bench/clock_gen.sv
bench/dual_issue_chk.sv
bench/dual_issue_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= dual_issue_tb
FILELIST  ?= dual_issue.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
FAIL_MSG  ?= Simulation failed
PASS_MSG  ?= Simulation completed successfully

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "FAIL: see $(LOG)"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "FAIL: run ended early, see $(LOG)"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
